// File: design/soc_pkg.sv
/* bus request struct, address map and I/O selects, UART bit timing,
   output queue sizing and host command codes */
package soc_pkg;

	// one bus access from either master
	typedef struct packed {
		logic [31:0] addr;
		logic        wr;
		logic [7:0]  data;
	} mem_req_t;

	// 128 KiB RAM; bits [17:16] both set select the I/O window
	localparam int RAM_ADDR_WIDTH = 17;

	// I/O selects within the window
	localparam logic [2:0] IO_SEL_OUT    = 3'd0;
	localparam logic [2:0] IO_SEL_FINISH = 3'd4;

	// short bit time keeps simulation fast
	localparam int CLKS_PER_BIT = 8;
	localparam int BAUD_CNT_W   = $clog2(CLKS_PER_BIT);
	localparam logic [BAUD_CNT_W-1:0] BAUD_LAST = BAUD_CNT_W'(CLKS_PER_BIT - 1);
	localparam logic [BAUD_CNT_W-1:0] BAUD_HALF = BAUD_CNT_W'(CLKS_PER_BIT / 2 - 1);

	// output queue, depth must be a power of two
	localparam int FIFO_DEPTH = 16;
	localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

	// host command codes
	localparam logic [7:0] CMD_READ   = 8'h10;
	localparam logic [7:0] CMD_WRITE  = 8'h11;
	localparam logic [7:0] CMD_BREAK  = 8'h12;
	localparam logic [7:0] CMD_RESUME = 8'h13;

endpackage

// File: design/ram.sv
/* single-port byte RAM, synchronous read */
`timescale 1ns/1ns

module ram (
	input  logic                               clk,
	input  logic                               en,
	input  logic                               wr,
	input  logic [soc_pkg::RAM_ADDR_WIDTH-1:0] addr,
	input  logic [7:0]                         din,
	output logic [7:0]                         dout
);

	logic [7:0] mem [0:(1 << soc_pkg::RAM_ADDR_WIDTH)-1];

	// read data follows the address by one cycle
	always_ff @(posedge clk) begin
		if (en) begin
			if (wr) begin
				mem[addr] <= din;
			end else begin
				dout <= mem[addr];
			end
		end
	end

endmodule

// File: design/uart_rx.sv
/* UART receiver: 8N1 frames to byte strobes */
`timescale 1ns/1ns

module uart_rx (
	input  logic       clk,
	input  logic       rst,
	input  logic       rx,
	output logic [7:0] data,
	output logic       valid
);

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

	rx_state_t                         state;
	logic                              rx_meta;
	logic                              rx_sync;
	logic [soc_pkg::BAUD_CNT_W-1:0]    baud_cnt;
	logic [2:0]                        bit_idx;

	// line idles high
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= RX_IDLE;
			baud_cnt <= '0;
			bit_idx <= '0;
			data <= '0;
			valid <= 1'b0;
		end else begin
			valid <= 1'b0;
			baud_cnt <= baud_cnt + 1'b1;
			case (state)
				RX_IDLE: begin
					baud_cnt <= '0;
					if (!rx_sync) begin
						state <= RX_START;
					end
				end
				// start bit must still be low at its middle
				RX_START: begin
					if (baud_cnt == soc_pkg::BAUD_HALF) begin
						baud_cnt <= '0;
						bit_idx <= '0;
						state <= rx_sync ? RX_IDLE : RX_DATA;
					end
				end
				RX_DATA: begin
					if (baud_cnt == soc_pkg::BAUD_LAST) begin
						baud_cnt <= '0;
						// lsb first
						data <= {rx_sync, data[7:1]};
						bit_idx <= bit_idx + 3'd1;
						if (bit_idx == 3'd7) begin
							state <= RX_STOP;
						end
					end
				end
				// framing error drops the byte
				RX_STOP: begin
					if (baud_cnt == soc_pkg::BAUD_LAST) begin
						valid <= rx_sync;
						state <= RX_IDLE;
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

endmodule

// File: design/uart_tx.sv
/* UART transmitter: one 8N1 frame per start strobe */
`timescale 1ns/1ns

module uart_tx (
	input  logic       clk,
	input  logic       rst,
	input  logic       start,
	input  logic [7:0] data,
	output logic       tx,
	output logic       busy
);

	logic [9:0]                     frame;
	logic [soc_pkg::BAUD_CNT_W-1:0] baud_cnt;
	logic [3:0]                     bit_cnt;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			frame <= '1;
			baud_cnt <= '0;
			bit_cnt <= '0;
			busy <= 1'b0;
		end else if (!busy) begin
			if (start) begin
				// stop bit, data lsb first, start bit
				frame <= {1'b1, data, 1'b0};
				baud_cnt <= '0;
				bit_cnt <= '0;
				busy <= 1'b1;
			end
		end else if (baud_cnt == soc_pkg::BAUD_LAST) begin
			baud_cnt <= '0;
			// ones shift in, so the line rests high after the stop bit
			frame <= {1'b1, frame[9:1]};
			if (bit_cnt == 4'd9) begin
				busy <= 1'b0;
			end else begin
				bit_cnt <= bit_cnt + 4'd1;
			end
		end else begin
			baud_cnt <= baud_cnt + 1'b1;
		end
	end

	assign tx = frame[0];

endmodule

// File: design/byte_fifo.sv
/* circular byte FIFO, first word fall through */
`timescale 1ns/1ns

module byte_fifo (
	input  logic       clk,
	input  logic       rst,
	input  logic       push,
	input  logic [7:0] push_data,
	input  logic       pop,
	output logic [7:0] pop_data,
	output logic       full,
	output logic       not_empty
);

	logic [7:0]                     mem [0:soc_pkg::FIFO_DEPTH-1];
	logic [soc_pkg::FIFO_PTR_W-1:0] wr_ptr;
	logic [soc_pkg::FIFO_PTR_W-1:0] rd_ptr;
	logic [soc_pkg::FIFO_PTR_W:0]   count;
	logic                           do_push;
	logic                           do_pop;

	assign do_push = push & ~full;
	assign do_pop = pop & not_empty;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			count <= count + {{soc_pkg::FIFO_PTR_W{1'b0}}, do_push}
				- {{soc_pkg::FIFO_PTR_W{1'b0}}, do_pop};
		end
	end

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	assign pop_data = mem[rd_ptr];
	// top count bit alone marks a full queue
	assign full = count[soc_pkg::FIFO_PTR_W];
	assign not_empty = (count != '0);

	// the transmitter side only pops what is there
	a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) pop |-> not_empty);

endmodule

// File: design/host_ctrl.sv
/* host command engine: break/resume, RAM peek/poke over UART,
   plus the master I/O window (output bytes, status, finish) */
`timescale 1ns/1ns

module host_ctrl (
	input  logic              clk,
	input  logic              rst,
	input  logic [7:0]        rx_data,
	input  logic              rx_valid,
	input  logic [7:0]        ram_dout,
	input  logic              io_en,
	input  logic [2:0]        io_sel,
	input  logic              io_wr,
	input  logic [7:0]        io_din,
	input  logic              fifo_full,
	output soc_pkg::mem_req_t host_req,
	output logic              host_active,
	output logic [7:0]        io_dout,
	output logic              push,
	output logic [7:0]        push_data,
	output logic              program_finish
);

	typedef enum logic [2:0] {ST_CMD, ST_ADDR, ST_DATA, ST_EXEC, ST_RESP} host_state_t;

	host_state_t state;
	logic        is_write;
	logic [1:0]  addr_cnt;
	logic [23:0] addr;
	logic [7:0]  wdata;
	logic        push_resp;
	logic        push_io;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= ST_CMD;
			host_active <= 1'b0;
			is_write <= 1'b0;
			addr_cnt <= '0;
			program_finish <= 1'b0;
			io_dout <= '0;
		end else begin
			program_finish <= io_en & io_wr & (io_sel == soc_pkg::IO_SEL_FINISH);
			// status byte, bit 0 is queue full
			io_dout <= (io_sel == soc_pkg::IO_SEL_OUT) ? {7'b0, fifo_full} : 8'h00;
			case (state)
				ST_CMD: begin
					if (rx_valid) begin
						case (rx_data)
							soc_pkg::CMD_READ, soc_pkg::CMD_WRITE: begin
								state <= ST_ADDR;
								addr_cnt <= '0;
								is_write <= (rx_data == soc_pkg::CMD_WRITE);
							end
							soc_pkg::CMD_BREAK: host_active <= 1'b1;
							soc_pkg::CMD_RESUME: host_active <= 1'b0;
							default: ;
						endcase
					end
				end
				// three address bytes, low byte first
				ST_ADDR: begin
					if (rx_valid) begin
						addr_cnt <= addr_cnt + 2'd1;
						if (addr_cnt == 2'd2) begin
							if (is_write) begin
								state <= ST_DATA;
							end else begin
								state <= host_active ? ST_EXEC : ST_CMD;
							end
						end
					end
				end
				// data byte is consumed even outside break, then dropped
				ST_DATA: begin
					if (rx_valid) begin
						state <= host_active ? ST_EXEC : ST_CMD;
					end
				end
				ST_EXEC: state <= is_write ? ST_CMD : ST_RESP;
				ST_RESP: state <= ST_CMD;
				default: state <= ST_CMD;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == ST_ADDR && rx_valid) begin
			addr <= {rx_data, addr[23:8]};
		end
		if (state == ST_DATA && rx_valid) begin
			wdata <= rx_data;
		end
	end

	// host reaches RAM only, never the I/O window
	assign host_req.addr = {{(32 - soc_pkg::RAM_ADDR_WIDTH){1'b0}},
		addr[soc_pkg::RAM_ADDR_WIDTH-1:0]};
	assign host_req.wr = (state == ST_EXEC) & is_write;
	assign host_req.data = wdata;

	// read response arrives from RAM the cycle after EXEC
	assign push_resp = (state == ST_RESP) & ~fifo_full;
	// full queue drops bytes from both sources
	assign push_io = io_en & io_wr & (io_sel == soc_pkg::IO_SEL_OUT) & ~fifo_full;
	assign push = push_resp | push_io;
	assign push_data = (state == ST_RESP) ? ram_dout : io_din;

	// master is stalled while a read response is queued
	a_one_push_source: assert property (@(posedge clk) disable iff (rst)
		!(push_resp && push_io));

endmodule

// File: design/mem_bus_mux.sv
/* master select, RAM/I/O address decode and registered read-return select */
`timescale 1ns/1ns

module mem_bus_mux (
	input  logic              clk,
	input  logic              rst,
	input  soc_pkg::mem_req_t cpu_req,
	input  soc_pkg::mem_req_t host_req,
	input  logic              host_active,
	input  logic [7:0]        ram_dout,
	input  logic [7:0]        io_dout,
	output logic              ram_en,
	output soc_pkg::mem_req_t ram_req,
	output logic              io_en,
	output logic [2:0]        io_sel,
	output logic              io_wr,
	output logic [7:0]        io_din,
	output logic [7:0]        cpu_din,
	output logic              cpu_rdy
);

	soc_pkg::mem_req_t bus_req;
	logic              io_region;
	logic              q_io_en;

	// host owns the bus during break
	assign bus_req = host_active ? host_req : cpu_req;

	assign io_region = (bus_req.addr[soc_pkg::RAM_ADDR_WIDTH:soc_pkg::RAM_ADDR_WIDTH-1] == 2'b11);

	assign ram_en = ~io_region;
	assign ram_req = bus_req;
	assign io_en = io_region;
	assign io_sel = bus_req.addr[2:0];
	assign io_wr = bus_req.wr;
	assign io_din = bus_req.data;

	// remember which side the last access went to
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			q_io_en <= 1'b0;
		end else begin
			q_io_en <= io_en;
		end
	end

	assign cpu_din = q_io_en ? io_dout : ram_dout;
	assign cpu_rdy = ~host_active;

	// a stalled master issues no write
	a_no_stalled_write: assert property (@(posedge clk) disable iff (rst)
		!cpu_rdy |-> !cpu_req.wr);

endmodule

// File: design/soc_top.sv
/* test SoC top: reset synchronizer, RAM, bus mux, host interface, UART and output queue */
`timescale 1ns/1ns

module soc_top (
	input  logic              clk,
	input  logic              btnC,
	input  logic              rx,
	output logic              tx,
	output logic              led,
	input  soc_pkg::mem_req_t cpu_req,
	output logic [7:0]        cpu_din,
	output logic              cpu_rdy,
	output logic              io_full,
	output logic              program_finish
);

	logic              rst;
	logic              rst_delay;
	logic              ram_en;
	soc_pkg::mem_req_t ram_req;
	logic [7:0]        ram_dout;
	soc_pkg::mem_req_t host_req;
	logic              host_active;
	logic              io_en;
	logic [2:0]        io_sel;
	logic              io_wr;
	logic [7:0]        io_din;
	logic [7:0]        io_dout;
	logic [7:0]        rx_data;
	logic              rx_valid;
	logic              push;
	logic [7:0]        push_data;
	logic [7:0]        pop_data;
	logic              fifo_full;
	logic              fifo_not_empty;
	logic              tx_busy;
	logic              tx_start;

	// reset asserts at once, releases two clocks after btnC falls
	always_ff @(posedge clk or posedge btnC) begin
		if (btnC) begin
			rst <= 1'b1;
			rst_delay <= 1'b1;
		end else begin
			rst_delay <= 1'b0;
			rst <= rst_delay;
		end
	end

	ram ram_inst (.clk(clk), .en(ram_en), .wr(ram_req.wr),
		.addr(ram_req.addr[soc_pkg::RAM_ADDR_WIDTH-1:0]), .din(ram_req.data), .dout(ram_dout));

	mem_bus_mux mem_bus_mux_inst (.clk(clk), .rst(rst), .cpu_req(cpu_req), .host_req(host_req),
		.host_active(host_active), .ram_dout(ram_dout), .io_dout(io_dout), .ram_en(ram_en),
		.ram_req(ram_req), .io_en(io_en), .io_sel(io_sel), .io_wr(io_wr), .io_din(io_din),
		.cpu_din(cpu_din), .cpu_rdy(cpu_rdy));

	host_ctrl host_ctrl_inst (.clk(clk), .rst(rst), .rx_data(rx_data), .rx_valid(rx_valid),
		.ram_dout(ram_dout), .io_en(io_en), .io_sel(io_sel), .io_wr(io_wr), .io_din(io_din),
		.fifo_full(fifo_full), .host_req(host_req), .host_active(host_active),
		.io_dout(io_dout), .push(push), .push_data(push_data), .program_finish(program_finish));

	uart_rx uart_rx_inst (.clk(clk), .rst(rst), .rx(rx), .data(rx_data), .valid(rx_valid));

	byte_fifo byte_fifo_inst (.clk(clk), .rst(rst), .push(push), .push_data(push_data),
		.pop(tx_start), .pop_data(pop_data), .full(fifo_full), .not_empty(fifo_not_empty));

	// idle transmitter takes the head byte
	assign tx_start = fifo_not_empty & ~tx_busy;

	uart_tx uart_tx_inst (.clk(clk), .rst(rst), .start(tx_start), .data(pop_data),
		.tx(tx), .busy(tx_busy));

	assign io_full = fifo_full;
	// lit while the host holds the bus
	assign led = host_active;

endmodule

// File: verif/soc_tb.sv
/* directed testbench for the test SoC: bus-master model, UART host model,
   byte and flag checks, cycle timeout */
`timescale 1ns/1ns

module soc_tb;

	// about five times the UART frames the tests use
	localparam int TIMEOUT_CYCLES = 20000;
	localparam int RAM_TESTS = 8;
	localparam int FRAME_CYCLES = 10 * soc_pkg::CLKS_PER_BIT;

	logic              clk = 1'b0;
	logic              btnC;
	logic              rx;
	logic              tx;
	logic              led;
	soc_pkg::mem_req_t cpu_req;
	logic [7:0]        cpu_din;
	logic              cpu_rdy;
	logic              io_full;
	logic              program_finish;

	int                cycles = 0;
	logic [31:0]       rng_state = 32'd90299;
	logic [7:0]        ram_model [int];
	logic [16:0]       ram_addrs [$];

	soc_top soc_top_inst (.clk(clk), .btnC(btnC), .rx(rx), .tx(tx), .led(led),
		.cpu_req(cpu_req), .cpu_din(cpu_din), .cpu_rdy(cpu_rdy), .io_full(io_full),
		.program_finish(program_finish));

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("test failed");
			$fatal(1);
		end
	end

	function automatic logic [31:0] next_random();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	// bits [17:16] both set open the I/O window
	function automatic logic [31:0] io_addr(input logic [2:0] sel);
		return {14'd0, 2'b11, 13'd0, sel};
	endfunction

	task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
		if (got !== exp) begin
			$display("mismatch at %0t ns: %s, got %02h, expected %02h", $time, what, got, exp);
			$display("test failed");
			$fatal(1);
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("mismatch at %0t ns: %s, got %b, expected %b", $time, what, got, exp);
			$display("test failed");
			$fatal(1);
		end
	endtask

	task automatic wait_bus_ready();
		while (cpu_rdy !== 1'b1) begin
			@(negedge clk);
		end
	endtask

	task automatic bus_write(input logic [31:0] addr, input logic [7:0] data);
		wait_bus_ready();
		cpu_req = '{addr: addr, wr: 1'b1, data: data};
		@(negedge clk);
		cpu_req = '0;
	endtask

	// read data is back one cycle after the access
	task automatic bus_read(input logic [31:0] addr, output logic [7:0] data);
		wait_bus_ready();
		cpu_req = '{addr: addr, wr: 1'b0, data: 8'h00};
		@(negedge clk);
		cpu_req = '0;
		data = cpu_din;
	endtask

	task automatic host_send_byte(input logic [7:0] b);
		rx = 1'b0;
		repeat (soc_pkg::CLKS_PER_BIT) @(negedge clk);
		for (int i = 0; i < 8; i++) begin
			rx = b[i];
			repeat (soc_pkg::CLKS_PER_BIT) @(negedge clk);
		end
		rx = 1'b1;
		repeat (soc_pkg::CLKS_PER_BIT) @(negedge clk);
	endtask

	task automatic host_recv_byte(output logic [7:0] b);
		while (tx !== 1'b0) begin
			@(negedge clk);
		end
		// middle of the start bit
		repeat (soc_pkg::CLKS_PER_BIT / 2 - 1) @(negedge clk);
		check_bit(tx, 1'b0, "uart start bit");
		for (int i = 0; i < 8; i++) begin
			repeat (soc_pkg::CLKS_PER_BIT) @(negedge clk);
			b[i] = tx;
		end
		repeat (soc_pkg::CLKS_PER_BIT) @(negedge clk);
		check_bit(tx, 1'b1, "uart stop bit");
	endtask

	task automatic send_address(input logic [16:0] a);
		logic [23:0] a24;
		a24 = {7'd0, a};
		host_send_byte(a24[7:0]);
		host_send_byte(a24[15:8]);
		host_send_byte(a24[23:16]);
	endtask

	task automatic peek_ram(input logic [16:0] a, output logic [7:0] data);
		host_send_byte(soc_pkg::CMD_READ);
		send_address(a);
		host_recv_byte(data);
	endtask

	task automatic poke_ram(input logic [16:0] a, input logic [7:0] data);
		host_send_byte(soc_pkg::CMD_WRITE);
		send_address(a);
		host_send_byte(data);
	endtask

	task automatic wait_led(input logic value);
		while (led !== value) begin
			@(negedge clk);
		end
	endtask

	task automatic reset_values();
		check_bit(tx, 1'b1, "tx after reset");
		check_bit(led, 1'b0, "led after reset");
		check_bit(cpu_rdy, 1'b1, "cpu_rdy after reset");
		check_bit(io_full, 1'b0, "io_full after reset");
		check_bit(program_finish, 1'b0, "program_finish after reset");
	endtask

	task automatic ram_write_read();
		logic [31:0] r;
		logic [16:0] a;
		logic [7:0]  got;
		for (int i = 0; i < RAM_TESTS; i++) begin
			r = next_random();
			a = r[16:0];
			bus_write({15'd0, a}, r[31:24]);
			ram_model[int'(a)] = r[31:24];
			ram_addrs.push_back(a);
		end
		foreach (ram_addrs[i]) begin
			bus_read({15'd0, ram_addrs[i]}, got);
			check_byte(got, ram_model[int'(ram_addrs[i])],
				$sformatf("master read of ram %05h", ram_addrs[i]));
		end
	endtask

	task automatic io_output_byte();
		logic [7:0] st;
		logic [7:0] b;
		bus_write(io_addr(soc_pkg::IO_SEL_OUT), 8'hC3);
		bus_read(io_addr(soc_pkg::IO_SEL_OUT), st);
		// a single queued byte leaves the queue far from full
		check_bit(io_full, 1'b0, "io_full with one byte queued");
		check_byte(st, 8'h00, "status byte");
		host_recv_byte(b);
		check_byte(b, 8'hC3, "output byte on tx");
	endtask

	// the lead byte keeps the transmitter busy while the burst fills the queue
	task automatic output_backpressure();
		logic [7:0] seen [$];
		logic [7:0] st;
		logic [7:0] b;
		fork
			begin
				bus_write(io_addr(soc_pkg::IO_SEL_OUT), 8'h5A);
				for (int i = 0; i < 17; i++) begin
					bus_write(io_addr(soc_pkg::IO_SEL_OUT), 8'hA0 + 8'(i));
				end
				check_bit(io_full, 1'b1, "io_full after burst");
				bus_read(io_addr(soc_pkg::IO_SEL_OUT), st);
				check_byte(st, 8'h01, "status byte while full");
			end
			begin
				for (int i = 0; i < 17; i++) begin
					host_recv_byte(b);
					seen.push_back(b);
				end
			end
		join
		check_byte(seen[0], 8'h5A, "lead byte on tx");
		for (int i = 0; i < 16; i++) begin
			check_byte(seen[i + 1], 8'hA0 + 8'(i), $sformatf("burst byte %0d on tx", i));
		end
		check_bit(io_full, 1'b0, "io_full after drain");
		// the dropped byte must never show up
		repeat (2 * FRAME_CYCLES) begin
			@(negedge clk);
			check_bit(tx, 1'b1, "tx idle after drain");
		end
	endtask

	task automatic break_and_debug();
		logic [16:0] a_read;
		logic [16:0] a_write;
		logic [31:0] r;
		logic [7:0]  new_data;
		logic [7:0]  b;
		a_read = ram_addrs[0];
		a_write = ram_addrs[1];
		r = next_random();
		new_data = r[7:0];
		if (new_data == ram_model[int'(a_write)]) begin
			new_data = ~new_data;
		end
		host_send_byte(soc_pkg::CMD_BREAK);
		wait_led(1'b1);
		check_bit(cpu_rdy, 1'b0, "cpu_rdy during break");
		peek_ram(a_read, b);
		check_byte(b, ram_model[int'(a_read)], "host read of master data");
		poke_ram(a_write, new_data);
		ram_model[int'(a_write)] = new_data;
		peek_ram(a_write, b);
		check_byte(b, new_data, "host read after host write");
		host_send_byte(soc_pkg::CMD_RESUME);
		wait_led(1'b0);
		check_bit(cpu_rdy, 1'b1, "cpu_rdy after resume");
		bus_read({15'd0, a_write}, b);
		check_byte(b, new_data, "master read of host data");
	endtask

	task automatic finish_pulse();
		check_bit(program_finish, 1'b0, "program_finish before write");
		bus_write(io_addr(soc_pkg::IO_SEL_FINISH), 8'h00);
		check_bit(program_finish, 1'b1, "program_finish pulse");
		@(negedge clk);
		check_bit(program_finish, 1'b0, "program_finish pulse end");
	endtask

	initial begin
		btnC = 1'b1;
		rx = 1'b1;
		cpu_req = '0;
		repeat (5) @(negedge clk);
		btnC = 1'b0;
		// internal reset lags btnC by two clocks
		repeat (3) @(negedge clk);
		reset_values();
		ram_write_read();
		io_output_byte();
		output_backpressure();
		break_and_debug();
		finish_pulse();
		$display("test passed");
		$finish;
	end

endmodule

// File: soc.f
design/soc_pkg.sv
design/ram.sv
design/uart_rx.sv
design/uart_tx.sv
design/byte_fifo.sv
design/host_ctrl.sv
design/mem_bus_mux.sv
design/soc_top.sv
verif/soc_tb.sv

// File: Makefile
SRCS := $(shell grep -v '^+' soc.f)

.PHONY: run clean

obj_dir/Vsoc_tb: soc.f $(SRCS)
	verilator --binary --timing --assert --top-module soc_tb -Mdir obj_dir -f soc.f

run: obj_dir/Vsoc_tb
	./obj_dir/Vsoc_tb > sim.log 2>&1; cat sim.log
	! grep -q "test failed" sim.log
	grep -q "test passed" sim.log

clean:
	rm -rf obj_dir sim.log
